//--- common/fp_round_consts.svh
`ifndef FP_ROUND_CONSTS_SVH
`define FP_ROUND_CONSTS_SVH

// single precision field widths
`define EXPO_WIDTH 8
`define FRAC_WIDTH 23
`define FLEN 32

// unrounded significand layout
//   bit 27     carry out of the arithmetic unit
//   bit 26     hidden bit
//   bits 25:3  fraction
//   bits 2:0   extra low bits for rounding
`define SIG_WIDTH 28

// working exponent is signed with two bits of headroom
// so overflow and underflow can be seen before packing
`define EXP_EXT_WIDTH (`EXPO_WIDTH + 2)

// 1 keeps all five rounding modes, 0 keeps ties-to-even only
`define FULL_ROUNDING_MODES_ENABLE 1

`endif

//--- common/fp_format_pkg.sv
`include "fp_round_consts.svh"

package fp_format_pkg;

    // ieee word split into its fields
    typedef struct packed {
        logic                   sign;
        logic [`EXPO_WIDTH-1:0] expo;  // biased exponent
        logic [`FRAC_WIDTH-1:0] frac;  // fraction without hidden bit
    } fp_fields_t;

    // same word seen as sign plus one magnitude
    // exponent and fraction sit side by side, so an add to the
    // magnitude lets a fraction carry ripple into the exponent
    typedef struct packed {
        logic              sign;
        logic [`FLEN-2:0]  mag;
    } fp_bits_t;

    // one word, two decodes
    // pack stage rounds through bits and checks overflow through fields
    typedef union packed {
        fp_fields_t fields;
        fp_bits_t   bits;
    } fp_word_u;

endpackage

//--- common/fp_round_pkg.sv
`include "fp_round_consts.svh"

package fp_round_pkg;

    // rounding mode codes, same encoding as the fcsr frm field
    typedef enum logic [2:0] {
        RM_RNE = 3'b000,  // nearest, ties to even
        RM_RTZ = 3'b001,  // toward zero
        RM_RDN = 3'b010,  // toward negative
        RM_RUP = 3'b011,  // toward positive
        RM_RMM = 3'b100   // nearest, ties to max magnitude
    } round_mode_e;

    // unrounded value from an arithmetic unit
    typedef struct packed {
        logic                             sign;
        logic signed [`EXP_EXT_WIDTH-1:0] expo;  // biased, valid when carry bit clear
        logic [`SIG_WIDTH-1:0]            sig;   // carry, hidden, fraction, 3 low bits
    } round_req_t;

    // normalized value ready for the rounding decision
    typedef struct packed {
        logic                             sign;
        logic signed [`EXP_EXT_WIDTH-1:0] expo;  // may fall outside the normal range
        logic [`FRAC_WIDTH-1:0]           frac;
        logic [2:0]                       grs;   // guard, round, sticky
        logic                             lsb;   // fraction lsb for ties to even
    } norm_t;

    // exception flags reported with each result
    typedef struct packed {
        logic inexact;
        logic overflow;
    } round_flags_t;

endpackage

//--- round/fp_normalize.sv
`timescale 1ns/100ps
`include "fp_round_consts.svh"

module fp_normalize (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      in_valid,
    input  fp_round_pkg::round_mode_e rm,
    input  fp_round_pkg::round_req_t  req,
    output logic                      norm_valid,
    output fp_round_pkg::round_mode_e norm_rm,
    output fp_round_pkg::norm_t       norm
);
    import fp_round_pkg::*;

    localparam int BODY_W = `SIG_WIDTH - 1;        // hidden bit and below
    localparam int LZC_W  = $clog2(`SIG_WIDTH);    // counts 0 to BODY_W

    logic              carry;
    logic [BODY_W-1:0] body;
    logic              sig_zero;
    logic [LZC_W-1:0]  lzc;
    logic [BODY_W-1:0] shifted;   // hidden bit lands on the top bit
    logic              dropped;   // bit lost by the right shift
    norm_t             norm_d;

    // leading zero count, highest set bit wins
    function automatic logic [LZC_W-1:0] lead_zeros(input logic [BODY_W-1:0] v);
        logic [LZC_W-1:0] cnt;
        cnt = LZC_W'(BODY_W);  // all zero
        for (int i = 0; i < BODY_W; i++) begin
            if (v[i])
                cnt = LZC_W'(BODY_W - 1 - i);
        end
        return cnt;
    endfunction

    assign carry    = req.sig[`SIG_WIDTH-1];
    assign body     = req.sig[BODY_W-1:0];
    assign sig_zero = (req.sig == '0);
    assign lzc      = lead_zeros(body);

    // carry set means one bit too many above the point
    always_comb begin
        if (carry) begin
            shifted = req.sig[`SIG_WIDTH-1:1];
            dropped = req.sig[0];
        end else begin
            shifted = body << lzc;  // cancelled result, pull hidden bit up
            dropped = 1'b0;
        end
    end

    always_comb begin
        norm_d.sign = req.sign;
        norm_d.frac = shifted[BODY_W-2 -: `FRAC_WIDTH];
        norm_d.lsb  = shifted[3];                          // fraction lsb
        // everything under the round bit collapses into sticky
        norm_d.grs  = {shifted[2], shifted[1], shifted[0] | dropped};

        if (sig_zero)
            norm_d.expo = '0;                              // exact zero
        else if (carry)
            norm_d.expo = req.expo + `EXP_EXT_WIDTH'(1);
        else
            norm_d.expo = req.expo - `EXP_EXT_WIDTH'(lzc);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            norm_valid <= 1'b0;
        end else begin
            norm_valid <= in_valid;
        end
    end

    // payload only moves on a real request
    always_ff @(posedge clk) begin
        if (in_valid) begin
            norm_rm <= rm;   // travels with its value
            norm    <= norm_d;
        end
    end

endmodule

//--- round/fp_round_simplified.sv
`timescale 1ns/100ps
`include "fp_round_consts.svh"

module fp_round_simplified (
    input  logic              sign,
    input  logic [2:0]        rm,
    input  logic [2:0]        grs,
    input  logic              lsb,
    output logic              roundup,
    output logic [`FLEN-1:0]  result_if_overflow
);
    import fp_round_pkg::*;

    logic [`FLEN-1:0] inf_word;    // signed infinity
    logic [`FLEN-1:0] max_word;    // largest finite of this sign
    logic             tie_even;    // nearest even rule
    logic             any_extra;   // something was cut off

    assign inf_word  = {sign, {`EXPO_WIDTH{1'b1}}, {`FRAC_WIDTH{1'b0}}};
    assign max_word  = {sign, {(`EXPO_WIDTH-1){1'b1}}, 1'b0, {`FRAC_WIDTH{1'b1}}};
    assign tie_even  = grs[2] & (lsb | grs[1] | grs[0]);
    assign any_extra = |grs;

    if (`FULL_ROUNDING_MODES_ENABLE) begin : g_full
        always_comb begin
            case (rm)
                RM_RMM: begin
                    result_if_overflow = inf_word;
                    roundup            = grs[2];  // half or more goes away from zero
                end
                RM_RUP: begin
                    // negative values only grow toward zero here
                    result_if_overflow = sign ? max_word : inf_word;
                    roundup            = ~sign & any_extra;
                end
                RM_RDN: begin
                    result_if_overflow = sign ? inf_word : max_word;
                    roundup            = sign & any_extra;  // magnitude up when negative
                end
                RM_RTZ: begin
                    result_if_overflow = max_word;
                    roundup            = 1'b0;  // plain truncation
                end
                default: begin  // RNE and unused codes
                    result_if_overflow = inf_word;
                    roundup            = tie_even;
                end
            endcase
        end
    end else begin : g_rne_only
        always_comb begin
            if (rm == RM_RNE) begin
                result_if_overflow = inf_word;
                roundup            = tie_even;
            end else begin
                // unsupported mode gives zero
                result_if_overflow = '0;
                roundup            = 1'b0;
            end
        end
    end

endmodule

//--- round/fp_round_pack.sv
`timescale 1ns/100ps
`include "fp_round_consts.svh"

module fp_round_pack (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       norm_valid,
    input  fp_round_pkg::norm_t        norm,
    input  logic                       roundup,
    input  logic [`FLEN-1:0]           result_if_overflow,
    output logic                       out_valid,
    output fp_format_pkg::fp_word_u    result,
    output fp_round_pkg::round_flags_t flags
);
    import fp_format_pkg::*;
    import fp_round_pkg::*;

    localparam logic signed [`EXP_EXT_WIDTH-1:0] EXP_ZERO = '0;
    localparam logic signed [`EXP_EXT_WIDTH-1:0] EXP_ONES =
        `EXP_EXT_WIDTH'((1 << `EXPO_WIDTH) - 1);

    fp_word_u     pre_word;    // truncated value
    fp_word_u     post_word;   // after the increment
    fp_word_u     result_d;
    round_flags_t flags_d;
    logic         underflow;
    logic         overflow;

    always_comb begin
        pre_word.fields.sign = norm.sign;
        pre_word.fields.expo = norm.expo[`EXPO_WIDTH-1:0];
        pre_word.fields.frac = norm.frac;

        // add one ulp on the magnitude, carry may reach the exponent
        post_word.bits.sign = pre_word.bits.sign;
        post_word.bits.mag  = pre_word.bits.mag + (`FLEN-1)'(roundup);
    end

    assign underflow = (norm.expo <= EXP_ZERO);  // no subnormals, flush
    // too big before rounding, or rounding carried into all ones
    assign overflow  = ~underflow &
                       ((norm.expo >= EXP_ONES) | (post_word.fields.expo == '1));

    always_comb begin
        result_d = post_word;
        flags_d.inexact  = |norm.grs;
        flags_d.overflow = 1'b0;
        if (underflow) begin
            result_d.fields.sign = norm.sign;   // signed zero
            result_d.fields.expo = '0;
            result_d.fields.frac = '0;
            flags_d.inexact      = 1'b1;
        end else if (overflow) begin
            result_d         = result_if_overflow;  // inf or max by mode
            flags_d.inexact  = 1'b1;
            flags_d.overflow = 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            result    <= '0;
            flags     <= '0;
        end else begin
            out_valid <= norm_valid;
            if (norm_valid) begin
                result <= result_d;
                flags  <= flags_d;
            end
        end
    end

endmodule

//--- source/fp_round_unit.sv
`timescale 1ns/100ps
`include "fp_round_consts.svh"

module fp_round_unit (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       in_valid,
    input  fp_round_pkg::round_mode_e  rm,
    input  fp_round_pkg::round_req_t   req,
    output logic                       out_valid,
    output fp_format_pkg::fp_word_u    result,
    output fp_round_pkg::round_flags_t flags
);
    import fp_round_pkg::*;

    logic             norm_valid;
    round_mode_e      norm_rm;             // mode aligned with norm
    norm_t            norm;
    logic             roundup;
    logic [`FLEN-1:0] result_if_overflow;

    // stage 1 normalize and grs
    fp_normalize u_normalize (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .rm         (rm),
        .req        (req),
        .norm_valid (norm_valid),
        .norm_rm    (norm_rm),
        .norm       (norm)
    );

    // rounding decision between the two registers
    fp_round_simplified u_round (
        .sign               (norm.sign),
        .rm                 (norm_rm),
        .grs                (norm.grs),
        .lsb                (norm.lsb),
        .roundup            (roundup),
        .result_if_overflow (result_if_overflow)
    );

    // stage 2 increment, range check, flags
    fp_round_pack u_pack (
        .clk                (clk),
        .rst_n              (rst_n),
        .norm_valid         (norm_valid),
        .norm               (norm),
        .roundup            (roundup),
        .result_if_overflow (result_if_overflow),
        .out_valid          (out_valid),
        .result             (result),
        .flags              (flags)
    );

endmodule

//--- test/fp_round_unit_assert.sv
`timescale 1ns/100ps

module fp_round_unit_assert (
    input logic                       clk,
    input logic                       rst_n,
    input logic                       in_valid,
    input logic                       out_valid,
    input fp_format_pkg::fp_word_u    result,
    input fp_round_pkg::round_flags_t flags
);

    // pipe stays empty while reset is held
    a_quiet_in_reset: assert property (@(posedge clk) !rst_n |-> !out_valid)
        else $error("out_valid high during reset");

    // fixed two stage latency, one result per request
    a_latency: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid == $past(in_valid, 2))
        else $error("out_valid does not follow in_valid by two cycles");

    // overflow is always inexact
    a_ovf_inexact: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && flags.overflow |-> flags.inexact)
        else $error("overflow flag without inexact");

    // all ones exponent means infinity, only reachable by overflow
    a_inf_needs_ovf: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && (result.fields.expo == '1) |-> flags.overflow)
        else $error("all ones exponent without overflow flag");

endmodule

bind fp_round_unit fp_round_unit_assert u_assert (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .out_valid (out_valid),
    .result    (result),
    .flags     (flags)
);

//--- test/fp_round_unit_tb.sv
`timescale 1ns/100ps
`include "fp_round_consts.svh"

module fp_round_unit_tb;
    import fp_format_pkg::*;
    import fp_round_pkg::*;

    localparam int MAX_GAP = 3;  // most idle cycles before a row in the gap pass

    // one table row with stimulus and hand worked answer
    typedef struct packed {
        round_mode_e      rm;
        round_req_t       req;
        logic [`FLEN-1:0] word;
        round_flags_t     flg;   // {inexact, overflow}
        logic [31:0]      sent;  // cycle the row went in
    } test_row_t;

    // mode sweep case where bit n of inc_mask is the increment for mode code n
    typedef struct packed {
        logic                  sign;
        logic [`SIG_WIDTH-1:0] sig;
        logic [`FLEN-1:0]      base;  // truncated word
        logic [4:0]            inc_mask;
    } sweep_t;

    localparam sweep_t SWEEP [8] = '{
        '{1'b0, 28'h4000004, 32'h3f800000, 5'b11000},  // half with even lsb
        '{1'b0, 28'h400000c, 32'h3f800001, 5'b11001},  // half with odd lsb
        '{1'b0, 28'h4000006, 32'h3f800000, 5'b11001},  // above half
        '{1'b0, 28'h4000002, 32'h3f800000, 5'b01000},  // below half
        '{1'b1, 28'h4000004, 32'hbf800000, 5'b10100},
        '{1'b1, 28'h400000c, 32'hbf800001, 5'b10101},
        '{1'b1, 28'h4000006, 32'hbf800000, 5'b10101},
        '{1'b1, 28'h4000002, 32'hbf800000, 5'b00100}
    };

    logic         clk = 1'b0;
    logic         rst_n;
    logic         in_valid;
    round_mode_e  rm;
    round_req_t   req;
    logic         out_valid;
    fp_word_u     result;
    round_flags_t flags;

    test_row_t rows[$];
    test_row_t expect_q[$];       // requests still in flight
    int        value_errors = 0;
    int        other_errors = 0;
    int        cycles = 0;
    int        cycle_limit = 1000;  // replaced once the table is built
    int        seed = 32'h65a1;

    fp_round_unit u_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .rm        (rm),
        .req       (req),
        .out_valid (out_valid),
        .result    (result),
        .flags     (flags)
    );

    always #10 clk = ~clk;  // 20 ns period

    // cycle count and watchdog
    always @(posedge clk) begin
        cycles++;
        if (cycles >= cycle_limit) begin
            $display("timeout: outputs still pending after %0d cycles", cycles);
            other_errors++;
            $display("errors: %0d value, %0d protocol", value_errors, other_errors);
            $display("Test failed");
            $finish;
        end
    end

    task automatic add_row(input round_mode_e m, input logic s, input int e,
                           input logic [`SIG_WIDTH-1:0] sig,
                           input logic [`FLEN-1:0] word, input logic [1:0] flg);
        test_row_t r;
        r          = '0;
        r.rm       = m;
        r.req.sign = s;
        r.req.expo = `EXP_EXT_WIDTH'(e);
        r.req.sig  = sig;
        r.word     = word;
        r.flg      = flg;
        rows.push_back(r);
    endtask

    task automatic build_table();
        // normalization
        add_row(RM_RNE, 1'b0, 127, 28'h4000000, 32'h3f800000, 2'b00);  // exact 1.0
        add_row(RM_RNE, 1'b0, 127, 28'h8000000, 32'h40000000, 2'b00);  // carry and exact
        add_row(RM_RNE, 1'b0, 127, 28'h8000001, 32'h40000000, 2'b10);  // dropped bit in sticky
        add_row(RM_RNE, 1'b0, 127, 28'hc000018, 32'h40400002, 2'b10);  // carry then odd tie
        add_row(RM_RNE, 1'b1, 127, 28'h0100000, 32'hbc800000, 2'b00);  // lzc 6
        add_row(RM_RNE, 1'b0, 127, 28'h000000c, 32'h34400000, 2'b00);  // lzc 23
        // all ones fraction ripples into the exponent
        add_row(RM_RNE, 1'b0, 127, 28'h7fffffc, 32'h40000000, 2'b10);
        // overflow to inf or max by mode and sign
        add_row(RM_RNE, 1'b0, 255, 28'h4000000, 32'h7f800000, 2'b11);
        add_row(RM_RTZ, 1'b1, 255, 28'h4000000, 32'hff7fffff, 2'b11);
        add_row(RM_RDN, 1'b0, 255, 28'h4000000, 32'h7f7fffff, 2'b11);
        add_row(RM_RDN, 1'b1, 255, 28'h4000000, 32'hff800000, 2'b11);
        add_row(RM_RUP, 1'b0, 255, 28'h4000000, 32'h7f800000, 2'b11);
        add_row(RM_RUP, 1'b1, 255, 28'h4000000, 32'hff7fffff, 2'b11);
        add_row(RM_RMM, 1'b1, 255, 28'h4000000, 32'hff800000, 2'b11);
        add_row(RM_RNE, 1'b0, 254, 28'h7fffffc, 32'h7f800000, 2'b11);  // by rounding
        add_row(RM_RTZ, 1'b0, 254, 28'h7fffffc, 32'h7f7fffff, 2'b10);  // truncated so it fits
        add_row(RM_RNE, 1'b0, 254, 28'h8000000, 32'h7f800000, 2'b11);  // by carry shift
        // underflow flush
        add_row(RM_RNE, 1'b1, 0, 28'h4000000, 32'h80000000, 2'b10);
        add_row(RM_RNE, 1'b0, 3, 28'h0100000, 32'h00000000, 2'b10);    // shift pushes below 1
        add_row(RM_RNE, 1'b1, -5, 28'h4000000, 32'h80000000, 2'b10);
        add_row(RM_RNE, 1'b0, 1, 28'h4000000, 32'h00800000, 2'b00);    // smallest normal
        // every mode on the same eight cases
        for (int m = 0; m < 5; m++) begin
            for (int k = 0; k < 8; k++) begin
                add_row(round_mode_e'(m), SWEEP[k].sign, 127, SWEEP[k].sig,
                        SWEEP[k].base + {31'b0, SWEEP[k].inc_mask[m]}, 2'b10);
            end
        end
    endtask

    task automatic send_row(input test_row_t r);
        test_row_t t;
        t = r;
        @(negedge clk);
        in_valid = 1'b1;
        rm       = t.rm;
        req      = t.req;
        t.sent   = cycles;  // sampled at the next rising edge
        expect_q.push_back(t);
    endtask

    task automatic idle_cycle();
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    task automatic wait_drain();
        while (expect_q.size() != 0)
            idle_cycle();
        repeat (3) idle_cycle();  // stray outputs show up here
    endtask

    // dut outputs change on the rising edge
    always @(negedge clk) begin
        test_row_t e;
        if (!rst_n) begin
            assert (out_valid == 1'b0) else begin
                $display("out_valid went high while reset was held");
                other_errors++;
            end
        end else if (out_valid) begin
            if (expect_q.size() == 0) begin
                $display("output appeared with no request in flight");
                other_errors++;
            end else begin
                e = expect_q.pop_front();
                assert (cycles - e.sent == 2) else begin
                    $display("result arrived %0d cycles after its request",
                             cycles - e.sent);
                    other_errors++;
                end
                assert (result === e.word) else begin
                    $display("** Error: result = %h, expected %h", result, e.word);
                    value_errors++;
                end
                assert (flags === e.flg) else begin
                    $display("** Error: flags = %h, expected %h", flags, e.flg);
                    value_errors++;
                end
            end
        end
    end

    initial begin
        int gap;
        in_valid = 1'b1;  // requests during reset must be dropped
        rm       = RM_RNE;
        req      = '0;
        rst_n    = 1'b0;
        build_table();
        cycle_limit = 8 + 2 * rows.size() + MAX_GAP * rows.size() + 20;
        repeat (4) @(posedge clk);
        @(negedge clk);
        in_valid = 1'b0;  // quiet for the last reset cycles
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // back to back with two in flight
        foreach (rows[i])
            send_row(rows[i]);
        wait_drain();

        // random valid gaps and the order must hold
        foreach (rows[i]) begin
            gap = $unsigned($random(seed)) % (MAX_GAP + 1);
            repeat (gap) idle_cycle();
            send_row(rows[i]);
        end
        wait_drain();

        $display("errors: %0d value, %0d protocol", value_errors, other_errors);
        if (value_errors + other_errors == 0)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    end

endmodule

//--- fp_round_unit.f
+incdir+common
common/fp_format_pkg.sv
common/fp_round_pkg.sv
round/fp_normalize.sv
round/fp_round_simplified.sv
round/fp_round_pack.sv
source/fp_round_unit.sv
test/fp_round_unit_assert.sv
test/fp_round_unit_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the rounding unit testbench with verilator, run it, then scan the log
cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert --top-module fp_round_unit_tb \
    -f fp_round_unit.f -o fp_round_unit_sim \
    && ./obj_dir/fp_round_unit_sim 2>&1 | tee "$log" \
    || { echo "build or run error"; exit 1; }

# a failing check prints the fail message, an aborted run prints no pass message
grep -q "Test failed" "$log" && { echo "simulation FAILED"; exit 1; }
grep -q "Test passed" "$log" || { echo "simulation aborted"; exit 1; }
echo "simulation PASSED"
